//--- verilog/img_cap_pkg.sv
// Image capture display package: pixel format, test colours and default video timing
package img_cap_pkg;

    //========================================
    // Pixel format
    //========================================
    localparam int pix_w = 24;                          // 8 bits each of R, G, B

    localparam logic [pix_w-1:0] pix_red   = 24'hff_00_00;  // Red byte on top
    localparam logic [pix_w-1:0] pix_blue  = 24'h00_00_ff;  // Blue byte at bottom
    localparam logic [pix_w-1:0] pix_black = 24'h00_00_00;  // Blanking / underflow fill

    //========================================
    // Video timing, 640x480p60
    //========================================
    localparam int cnt_w = 12;                          // Wide enough for 800 x 525

    // Horizontal, in pixel clocks
    localparam logic [cnt_w-1:0] def_h_active = 12'd640;
    localparam logic [cnt_w-1:0] def_h_fp     = 12'd16;
    localparam logic [cnt_w-1:0] def_h_sync   = 12'd96;
    localparam logic [cnt_w-1:0] def_h_bp     = 12'd48;

    // Vertical, in lines
    localparam logic [cnt_w-1:0] def_v_active = 12'd480;
    localparam logic [cnt_w-1:0] def_v_fp     = 12'd10;
    localparam logic [cnt_w-1:0] def_v_sync   = 12'd2;
    localparam logic [cnt_w-1:0] def_v_bp     = 12'd33;

    //========================================
    // Buffering
    //========================================
    // Power of two so the pointer wrap bit works
    localparam int def_fifo_depth = 16;

endpackage

//--- verilog/sync_gen.sv
// Video timing generator: line and frame counters decoded into raw de, hs and vs
`timescale 1ns/1ps

module sync_gen #(
    parameter logic [img_cap_pkg::cnt_w-1:0] h_active = img_cap_pkg::def_h_active,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_fp     = img_cap_pkg::def_h_fp,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_sync   = img_cap_pkg::def_h_sync,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_bp     = img_cap_pkg::def_h_bp,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_active = img_cap_pkg::def_v_active,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_fp     = img_cap_pkg::def_v_fp,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_sync   = img_cap_pkg::def_v_sync,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_bp     = img_cap_pkg::def_v_bp
) (
    input  logic clk_25_2m,
    input  logic reset,      // Sync, active low
    output logic raw_de,     // Active video
    output logic raw_hs,     // Horizontal sync, active high
    output logic raw_vs      // Vertical sync, active high
);
    import img_cap_pkg::*;

    // Line layout: active | front porch | sync | back porch
    localparam logic [cnt_w-1:0] h_total    = h_active + h_fp + h_sync + h_bp;
    localparam logic [cnt_w-1:0] h_last     = h_total - 1'b1;
    localparam logic [cnt_w-1:0] hs_start   = h_active + h_fp;
    localparam logic [cnt_w-1:0] hs_end     = h_active + h_fp + h_sync;   // First cycle after

    // Frame layout, same order in lines
    localparam logic [cnt_w-1:0] v_total    = v_active + v_fp + v_sync + v_bp;
    localparam logic [cnt_w-1:0] v_last     = v_total - 1'b1;
    localparam logic [cnt_w-1:0] vs_start   = v_active + v_fp;
    localparam logic [cnt_w-1:0] vs_end     = v_active + v_fp + v_sync;

    logic [cnt_w-1:0] h_cnt;   // Pixel within line
    logic [cnt_w-1:0] v_cnt;   // Line within frame
    logic             h_wrap;  // Last pixel of the line

    assign h_wrap = (h_cnt == h_last);

    //========================================
    // Counters
    //========================================
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            h_cnt <= '0;   // Start of first active line
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                // Vertical steps once per line
                if (v_cnt == v_last)
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    //========================================
    // Decode
    //========================================
    // Straight compares against the boundaries, no extra register stage
    assign raw_de = (h_cnt < h_active) && (v_cnt < v_active);
    assign raw_hs = (h_cnt >= hs_start) && (h_cnt < hs_end);
    assign raw_vs = (v_cnt >= vs_start) && (v_cnt < vs_end);   // Whole lines

endmodule

//--- verilog/test_src_fsm.sv
// Simulated camera: writes red and blue pixels in turn once memory is ready
`timescale 1ns/1ps

module test_src_fsm (
    input  logic                          clk_25_2m,
    input  logic                          reset,     // Sync, active low
    input  logic                          ram_rdy,   // Memory ready level
    input  logic                          full,      // FIFO back-pressure
    output logic                          wr_en,
    output logic [img_cap_pkg::pix_w-1:0] wr_data
);
    import img_cap_pkg::*;

    // State encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_red  = 2'd1;
    localparam logic [1:0] st_blue = 2'd2;

    logic [1:0] state;
    logic [1:0] next_col;   // Colour to send on the next write

    //========================================
    // State register
    //========================================
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            state    <= st_idle;
            next_col <= st_red;                // Sequence opens with red
        end else begin
            case (state)
                st_idle: begin
                    // Hold here on a stall, next_col keeps its place
                    if (ram_rdy && !full)
                        state <= next_col;
                end
                st_red: begin
                    state    <= st_idle;       // One write, then back
                    next_col <= st_blue;
                end
                st_blue: begin
                    state    <= st_idle;
                    next_col <= st_red;
                end
                default: state <= st_idle;     // Unused code
            endcase
        end
    end

    //========================================
    // Write decode
    //========================================
    // No write in idle, so full cannot rise between the check and the write
    always_comb begin
        wr_en   = 1'b0;
        wr_data = pix_black;
        case (state)
            st_red: begin
                wr_en   = 1'b1;
                wr_data = pix_red;
            end
            st_blue: begin
                wr_en   = 1'b1;
                wr_data = pix_blue;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/pixel_fifo.sv
// Pixel FIFO: single clock, show-ahead head word, full and empty from the pointers
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int fifo_depth = img_cap_pkg::def_fifo_depth   // Power of two, 4 or more
) (
    input  logic                          clk_25_2m,
    input  logic                          reset,     // Sync, active low
    input  logic                          wr_en,
    input  logic [img_cap_pkg::pix_w-1:0] wr_data,
    input  logic                          rd_en,     // Pop the head word
    output logic [img_cap_pkg::pix_w-1:0] rd_data,   // Head word, no read delay
    output logic                          full,
    output logic                          empty
);
    import img_cap_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);

    logic [pix_w-1:0] mem [fifo_depth];   // Storage
    logic [addr_w:0]  wr_ptr;             // Top bit counts laps
    logic [addr_w:0]  rd_ptr;
    logic             do_wr;
    logic             do_rd;

    //========================================
    // Flags
    //========================================
    // Same lap and same slot means nothing stored
    assign empty = (wr_ptr == rd_ptr);
    // Writer one lap ahead on the same slot
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign do_wr = wr_en && !full;    // Overflow write dropped
    assign do_rd = rd_en && !empty;

    //========================================
    // Pointers
    //========================================
    // Independent updates, so a push with a pop keeps the count
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk_25_2m) begin
        if (do_wr)
            mem[wr_ptr[addr_w-1:0]] <= wr_data;
    end

    assign rd_data = mem[rd_ptr[addr_w-1:0]];   // Show-ahead

endmodule

//--- verilog/pixel_out.sv
// HDMI output stage: pops pixels during active video, fills black on underflow, delays syncs
`timescale 1ns/1ps

module pixel_out (
    input  logic                          clk_25_2m,
    input  logic                          reset,      // Sync, active low
    input  logic                          raw_de,
    input  logic                          raw_hs,
    input  logic                          raw_vs,
    input  logic [img_cap_pkg::pix_w-1:0] rd_data,    // FIFO head word
    input  logic                          empty,
    output logic                          rd_en,
    output logic [img_cap_pkg::pix_w-1:0] hdmi_d,
    output logic                          hdmi_de,
    output logic                          hdmi_hs,
    output logic                          hdmi_vs,
    output logic                          underflow   // Sticky until reset
);
    import img_cap_pkg::*;

    logic starve;   // Active pixel with nothing to show

    assign rd_en  = raw_de && !empty;
    assign starve = raw_de && empty;

    //========================================
    // Output registers
    //========================================
    // Everything lines up one cycle after the counters
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            hdmi_d    <= pix_black;
            hdmi_de   <= 1'b0;
            hdmi_hs   <= 1'b0;
            hdmi_vs   <= 1'b0;
            underflow <= 1'b0;
        end else begin
            hdmi_de <= raw_de;
            hdmi_hs <= raw_hs;
            hdmi_vs <= raw_vs;
            // Popped word, else black in blanking or when starved
            hdmi_d  <= rd_en ? rd_data : pix_black;
            if (starve)
                underflow <= 1'b1;   // Latch first miss
        end
    end

endmodule

//--- verilog/img_cap_top.sv
// Image capture display top: test source into pixel FIFO, drained to HDMI by the timing chain
`timescale 1ns/1ps

module img_cap_top #(
    parameter logic [img_cap_pkg::cnt_w-1:0] h_active = img_cap_pkg::def_h_active,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_fp     = img_cap_pkg::def_h_fp,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_sync   = img_cap_pkg::def_h_sync,
    parameter logic [img_cap_pkg::cnt_w-1:0] h_bp     = img_cap_pkg::def_h_bp,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_active = img_cap_pkg::def_v_active,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_fp     = img_cap_pkg::def_v_fp,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_sync   = img_cap_pkg::def_v_sync,
    parameter logic [img_cap_pkg::cnt_w-1:0] v_bp     = img_cap_pkg::def_v_bp,
    parameter int fifo_depth = img_cap_pkg::def_fifo_depth
) (
    input  logic                          clk_25_2m,   // Pixel clock
    input  logic                          reset,       // Sync, active low
    input  logic                          ram_rdy,     // Memory ready level
    output logic [img_cap_pkg::pix_w-1:0] hdmi_d,
    output logic                          hdmi_de,
    output logic                          hdmi_hs,
    output logic                          hdmi_vs,
    output logic                          underflow    // Sticky status lamp
);
    import img_cap_pkg::*;

    // Source side of the FIFO
    logic             wr_en;
    logic [pix_w-1:0] wr_data;
    logic             full;

    // Display side of the FIFO
    logic             rd_en;
    logic [pix_w-1:0] rd_data;
    logic             empty;

    // Raw timing, one cycle ahead of the pins
    logic raw_de;
    logic raw_hs;
    logic raw_vs;

    //========================================
    // Video timing
    //========================================
    sync_gen #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) i_sync_gen (
        .clk_25_2m(clk_25_2m), .reset(reset),
        .raw_de(raw_de), .raw_hs(raw_hs), .raw_vs(raw_vs)
    );

    //========================================
    // Pixel path
    //========================================
    test_src_fsm i_test_src (
        .clk_25_2m(clk_25_2m), .reset(reset), .ram_rdy(ram_rdy),
        .full(full), .wr_en(wr_en), .wr_data(wr_data)
    );

    pixel_fifo #(.fifo_depth(fifo_depth)) i_pixel_fifo (
        .clk_25_2m(clk_25_2m), .reset(reset),
        .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data),
        .full(full), .empty(empty)
    );

    pixel_out i_pixel_out (
        .clk_25_2m(clk_25_2m), .reset(reset),
        .raw_de(raw_de), .raw_hs(raw_hs), .raw_vs(raw_vs),
        .rd_data(rd_data), .empty(empty), .rd_en(rd_en),
        .hdmi_d(hdmi_d), .hdmi_de(hdmi_de), .hdmi_hs(hdmi_hs), .hdmi_vs(hdmi_vs),
        .underflow(underflow)
    );

endmodule

//--- verification/tb_img_cap.sv
// Directed testbench for the display path: reset, video timing, underflow and colour order
`timescale 1ns/1ps

module tb_img_cap;
    import img_cap_pkg::*;

    //========================================
    // Shrunk frame, 16-cycle lines, 8 lines
    //========================================
    localparam int h_active     = 8;
    localparam int h_fp         = 2;
    localparam int h_sync       = 3;
    localparam int h_bp         = 3;
    localparam int v_active     = 4;
    localparam int v_fp         = 1;
    localparam int v_sync       = 2;
    localparam int v_bp         = 1;
    localparam int h_total      = h_active + h_fp + h_sync + h_bp;
    localparam int v_total      = v_active + v_fp + v_sync + v_bp;
    localparam int frame_cycles = h_total * v_total;

    logic             clk_25_2m = 1'b0;   // Low before any process starts
    logic             reset;       // Active low
    logic             ram_rdy;
    logic [pix_w-1:0] hdmi_d;
    logic             hdmi_de;
    logic             hdmi_hs;
    logic             hdmi_vs;
    logic             underflow;
    logic             exp_red;     // Next colour expected on screen
    int               pix_count;   // Coloured active pixels seen

    img_cap_top #(
        .h_active(cnt_w'(h_active)), .h_fp(cnt_w'(h_fp)),
        .h_sync(cnt_w'(h_sync)), .h_bp(cnt_w'(h_bp)),
        .v_active(cnt_w'(v_active)), .v_fp(cnt_w'(v_fp)),
        .v_sync(cnt_w'(v_sync)), .v_bp(cnt_w'(v_bp)),
        .fifo_depth(4)
    ) i_dut (
        .clk_25_2m(clk_25_2m), .reset(reset), .ram_rdy(ram_rdy),
        .hdmi_d(hdmi_d), .hdmi_de(hdmi_de), .hdmi_hs(hdmi_hs), .hdmi_vs(hdmi_vs),
        .underflow(underflow)
    );

    initial begin
        clk_25_2m = 1'b0;
        forever #50 clk_25_2m = ~clk_25_2m;   // 100 ns period
    end

    //========================================
    // Reporting and waits
    //========================================
    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic sig_value(input string name);
        if (name == "hdmi_de") return hdmi_de;
        if (name == "hdmi_vs") return hdmi_vs;
        return underflow;
    endfunction

    // Steps on falling edges until the level shows up
    task automatic wait_level(input string name, input logic level, input int limit);
        int n;
        for (n = 0; n < limit; n++) begin
            if (sig_value(name) === level)
                break;
            @(negedge clk_25_2m);
        end
        assert (n < limit) else report_error({"timeout waiting for ", name});
    endtask

    // Holds reset 5 cycles while the outputs stay idle
    task automatic reset_and_check(input logic rdy);
        int i;
        reset   = 1'b0;
        ram_rdy = rdy;
        for (i = 0; i < 5; i++) begin
            @(negedge clk_25_2m);
            expect_eq("hdmi_de", 1'b0, hdmi_de);
            expect_eq("hdmi_hs", 1'b0, hdmi_hs);
            expect_eq("hdmi_vs", 1'b0, hdmi_vs);
            expect_eq("underflow", 1'b0, underflow);
            expect_eq("hdmi_d", pix_black, hdmi_d);
        end
        reset = 1'b1;
        exp_red   = 1'b1;   // Sequence restarts at red
        pix_count = 0;
    endtask

    // Checks one sample against the red and blue alternation, black allowed as a gap
    task automatic track_colour();
        if (hdmi_de && hdmi_d !== pix_black) begin
            expect_eq("hdmi_d", exp_red ? pix_red : pix_blue, hdmi_d);
            exp_red   = ~exp_red;
            pix_count = pix_count + 1;
        end else if (!hdmi_de) begin
            expect_eq("hdmi_d", pix_black, hdmi_d);   // Blanking is black
        end
    endtask

    //========================================
    // Tests
    //========================================
    task automatic underflow_no_source();
        int k;
        reset_and_check(1'b0);                       // No source at all
        wait_level("underflow", 1'b1, frame_cycles);
        for (k = 0; k < frame_cycles; k++) begin
            expect_eq("underflow", 1'b1, underflow);   // Sticky
            if (hdmi_de)
                expect_eq("hdmi_d", pix_black, hdmi_d);
            @(negedge clk_25_2m);
        end
    endtask

    task automatic line_frame_timing();
        int k;
        int px;
        int ln;
        wait_level("hdmi_vs", 1'b1, 2 * frame_cycles);
        wait_level("hdmi_vs", 1'b0, 2 * frame_cycles);
        wait_level("hdmi_de", 1'b1, 2 * frame_cycles);   // First pixel of a frame
        // Two whole frames, so the repeat is covered too
        for (k = 0; k < 2 * frame_cycles; k++) begin
            px = k % h_total;               // Cycle within line
            ln = (k / h_total) % v_total;   // Line within frame
            expect_eq("hdmi_de", px < h_active && ln < v_active, hdmi_de);
            expect_eq("hdmi_hs", px >= h_active + h_fp && px < h_active + h_fp + h_sync, hdmi_hs);
            expect_eq("hdmi_vs", ln >= v_active + v_fp && ln < v_active + v_fp + v_sync, hdmi_vs);
            @(negedge clk_25_2m);
        end
    endtask

    task automatic colour_sequence();
        int k;
        reset_and_check(1'b1);   // Memory ready from the start
        for (k = 0; k < 3 * frame_cycles; k++) begin
            @(negedge clk_25_2m);
            track_colour();
        end
        assert (pix_count >= 3 * v_active) else report_error("too few coloured pixels shown");
    endtask

    task automatic colour_under_stalls();
        int k;
        int hold;
        reset_and_check(1'b0);
        hold = 0;
        for (k = 0; k < 6 * frame_cycles; k++) begin
            @(negedge clk_25_2m);
            track_colour();
            if (hold == 0) begin
                ram_rdy = ~ram_rdy;              // Memory comes and goes
                hold    = $urandom_range(24, 1);
            end else begin
                hold = hold - 1;
            end
        end
        assert (pix_count >= v_active) else report_error("source made no progress under stalls");
    endtask

    initial begin
        reset    = 1'b0;
        ram_rdy  = 1'b0;
        void'($urandom(32'hc17b_5eb8));   // Single seed for the run
        underflow_no_source();
        line_frame_timing();
        colour_sequence();
        colour_under_stalls();
        $display("Test OK");
        $finish;
    end

endmodule

//--- filelist.f
verilog/img_cap_pkg.sv
verilog/sync_gen.sv
verilog/test_src_fsm.sv
verilog/pixel_fifo.sv
verilog/pixel_out.sv
verilog/img_cap_top.sv
verification/tb_img_cap.sv

//--- Makefile
# Verilator build and run for the display path testbench

VERILATOR ?= verilator
TOP       ?= tb_img_cap
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the pass line decides the status
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
